/* compile.f */
+incdir+source
+incdir+verif
source/rvDecodePkg.sv
source/decodeCtrlIf.sv
source/regFieldIf.sv
source/opcodeClassifier.sv
source/regFieldMapper.sv
source/immediateGen.sv
source/operandRouter.sv
source/rvDecodeTop.sv
verif/rvDecodeTb.sv

/* verif/rvDecodeVectors.svh */
/*
 decoder vectors, included into the testbench module body
 needs addVector and gprCode from the testbench and rvDecodePkg imported
 immediates are the 33-bit values the execute stage sees
*/
`ifndef RVDECODE_VECTORS_SVH
`define RVDECODE_VECTORS_SVH

// columns: name, instruction word, uCmd, uIxt, regN, regM, regO, regP, imm
function automatic void loadVectors();
	addVector("add", 32'h013908B3, {CC_AL, NM_ALU3}, {IUC_SC, UX_ALU_ADD},
		gprCode(17), gprCode(18), gprCode(19), gprCode(17), 33'h013);
	addVector("sub_remap", 32'h40E10A33, {CC_AL, NM_ALU3}, {IUC_SC, UX_ALU_SUB},
		gprCode(20), GR_SP, gprCode(2), gprCode(20), 33'h40E);
	addVector("sra", 32'h417B5AB3, {CC_AL, NM_SHADQ3}, {IUC_SC, UX_SHAD_SHARQ3},
		gprCode(21), gprCode(22), gprCode(23), gprCode(21), 33'h417);
	addVector("mulhu", 32'h03ACBC33, {CC_AL, NM_QMULDIV}, {IUC_SC, UX_QMUL_MULHU},
		gprCode(24), gprCode(25), gprCode(26), gprCode(24), 33'h03A);
	addVector("addi_neg", 32'hFFB08813, {CC_AL, NM_ALU3}, {IUC_SC, UX_ALU_ADD},
		gprCode(16), GR_LR, GR_IMM, gprCode(16), 33'h1_FFFF_FFFB);
	addVector("srai", 32'h40395893, {CC_AL, NM_SHADQ3}, {IUC_SC, UX_SHAD_SHARQ3},
		gprCode(17), gprCode(18), GR_IMM, gprCode(17), 33'h403);
	// load displacement is zero-extended
	addVector("lw", 32'hFFC8A803, {CC_AL, NM_MOV_MR}, {IUC_SC, 6'b100000},
		gprCode(16), gprCode(17), GR_IMM, gprCode(16), 33'h0_0000_0FFC);
	addVector("ld_uq", 32'h01037903, {CC_AL, NM_MOV_MR}, {IUC_WX, 6'b110100},
		gprCode(18), GR_DLR, GR_IMM, gprCode(18), 33'h010);
	addVector("sw", 32'hFF3A2C23, {CC_AL, NM_MOV_RM}, {IUC_SC, 6'b100000},
		gprCode(19), gprCode(20), GR_IMM, gprCode(19), 33'h1_FFFF_FFF8);
	// branch displacements in halfwords
	addVector("blt", 32'hFF184EE3, {CC_AL, NM_JCMP}, {IUC_SC, UX_JCMP_QLT},
		GR_ZZR, gprCode(16), gprCode(17), GR_ZZR, 33'h1_FFFF_FFFE);
	addVector("bgeu_remap", 32'h00F1F463, {CC_AL, NM_JCMP}, {IUC_SC, UX_JCMP_QHS},
		GR_ZZR, GR_GBR, gprCode(3), GR_ZZR, 33'h004);
	addVector("jal", 32'h001000EF, {CC_AL, NM_JSR}, {IUC_SC, 6'b010001},
		GR_LR, GR_PC, GR_IMM, GR_LR, 33'h400);
	addVector("jal_x0", 32'hFF9FF06F, {CC_AL, NM_JMP}, {IUC_SC, 6'b010001},
		GR_ZZR, GR_PC, GR_IMM, GR_ZZR, 33'h1_FFFF_FFFC);
	addVector("jalr", 32'h00C908E7, {CC_AL, NM_JSR}, {IUC_SC, 6'h00},
		gprCode(17), gprCode(18), GR_IMM, gprCode(17), 33'h00C);
	addVector("lui", 32'h80001A37, {CC_AL, NM_MOV_IR}, {IUC_SC, UX_LDI_LDIX},
		gprCode(20), gprCode(20), GR_IMM, gprCode(20), 33'h0_8000_1000);
	addVector("auipc", 32'hFFFFFA97, {CC_AL, NM_LEA_MR}, {IUC_SC, 6'h00},
		gprCode(21), GR_PC, GR_IMM, gprCode(21), 33'h0_FFFF_F000);
	addVector("ecall", 32'h00000073, {CC_AL, NM_OP_IXT}, {IUC_SC, UX_IXT_SYSE},
		GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, 33'h0);
	addVector("ebreak", 32'h00100073, {CC_AL, NM_OP_IXT}, {IUC_SC, UX_IXT_BREAK},
		GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, 33'h0);
	addVector("return", 32'h00200073, {CC_AL, NM_OP_IXT}, {IUC_SC, UX_IXT_RTE},
		GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, 33'h0);
	addVector("sleep", 32'h10500073, {CC_AL, NM_OP_IXT}, {IUC_SC, UX_IXT_SLEEP},
		GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, 33'h0);
	// csr 0x7C5, index 0x05 with bit 5 flipped
	addVector("csr_write", 32'h7C589073, {CC_AL, NM_MOV_RC}, {IUC_SC, 6'h00},
		GR_CR_BASE + 7'h25, gprCode(17), GR_CR_BASE + 7'h25, GR_CR_BASE + 7'h25, 33'h005);
	addVector("csr_read", 32'hBC302973, {CC_AL, NM_MOV_CR}, {IUC_SC, 6'h00},
		gprCode(18), 7'h03, 7'h03, gprCode(18), 33'h003);
	addVector("cpuid", 32'hFC1829F3, {CC_AL, NM_OP_IXT}, {IUC_SC, UX_IXT_CPUID},
		gprCode(19), 7'h01, 7'h01, gprCode(19), 33'h001);
	addVector("system_bad", 32'h0128C873, {CC_AL, NM_INVOP}, {IUC_SC, 6'h00},
		gprCode(16), gprCode(17), gprCode(18), gprCode(16), 33'h012);
	addVector("op32", 32'h013908BB, {CC_AL, NM_INVOP}, {IUC_SC, 6'h00},
		GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, 33'h0);
	addVector("short", 32'h00004501, {CC_AL, NM_INVOP}, {IUC_SC, 6'h00},
		GR_ZZR, GR_ZZR, GR_ZZR, GR_ZZR, 33'h0);
endfunction

`endif

/* verif/rvDecodeTb.sv */
/*
 testbench for rvDecodeTop
 applies the vector table with 0 to 3 random idle cycles between words
 every result is expected exactly one clock after its word is sampled
 imm and uIxt have no reset value and are only checked after a valid word
*/
`timescale 1ns/1ps

module rvDecodeTb;
	import rvDecodePkg::*;

	typedef struct {
		string name;
		instrT word;
		uCmdT cmd;
		uIxtT ixt;
		regIdT n;
		regIdT m;
		regIdT o;
		regIdT p;
		immT imm;
		int due;
	} vectorT;

	logic clock;
	logic reset;
	logic instrValid;
	instrT instrWord;
	logic decValid;
	regIdT regN;
	regIdT regM;
	regIdT regO;
	regIdT regP;
	immT imm;
	uCmdT uCmd;
	uIxtT uIxt;

	vectorT vectors[$];
	vectorT pending[$];
	vectorT last;
	bit haveLast = 1'b0;
	int cycle = 0;
	int checkCount = 0;
	int errorCount = 0;

	rvDecodeTop i_rvDecodeTop (
		.clock(clock),
		.reset(reset),
		.instrValid(instrValid),
		.instrWord(instrWord),
		.decValid(decValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.regP(regP),
		.imm(imm),
		.uCmd(uCmd),
		.uIxt(uIxt)
	);

	function automatic regIdT gprCode(input int n);
		return regIdT'(n);
	endfunction

	function automatic void addVector(input string name, input instrT word, input uCmdT cmd,
		input uIxtT ixt, input regIdT n, input regIdT m, input regIdT o, input regIdT p,
		input immT expImm);
		vectors.push_back('{name, word, cmd, ixt, n, m, o, p, expImm, 0});
	endfunction

	`include "rvDecodeVectors.svh"

	task automatic checkCmd(input string name, input uCmdT expected, input uCmdT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s uCmd expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkIxt(input string name, input uIxtT expected, input uIxtT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s uIxt expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkReg(input string name, input string what, input regIdT expected,
		input regIdT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s %s expected %h actual %h", name, what, expected, actual);
		end
	endtask

	task automatic checkImm(input string name, input immT expected, input immT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s imm expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic compareOutputs(input vectorT item);
		checkCmd(item.name, item.cmd, uCmd);
		checkIxt(item.name, item.ixt, uIxt);
		checkReg(item.name, "regN", item.n, regN);
		checkReg(item.name, "regM", item.m, regM);
		checkReg(item.name, "regO", item.o, regO);
		checkReg(item.name, "regP", item.p, regP);
		checkImm(item.name, item.imm, imm);
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// cycle stamp, read on both edges
	always @(negedge clock) cycle <= cycle + 1;

	// oldest word in flight is matched against each decValid
	always @(negedge clock) begin : checkOutputs
		vectorT item;
		if (!reset && decValid === 1'b1) begin
			if (pending.size() == 0) begin
				errorCount++;
				$display("decValid high with no word in flight at cycle %0d", cycle);
			end else begin
				item = pending.pop_front();
				if (item.due != cycle) begin
					errorCount++;
					$display("%s came out at cycle %0d instead of %0d", item.name, cycle, item.due);
				end
				compareOutputs(item);
				last = item;
				haveLast = 1'b1;
			end
		end else if (!reset) begin
			// outputs hold while decValid is low
			if (haveLast) begin
				item = last;
				item.name = {last.name, " hold"};
				compareOutputs(item);
			end
			if (pending.size() != 0 && pending[0].due <= cycle) begin
				item = pending.pop_front();
				errorCount++;
				$display("no decValid for %s by cycle %0d", item.name, cycle);
			end
		end
	end

	initial begin : runVectors
		int gap;
		int waited;
		vectorT item;
		reset = 1'b1;
		instrValid = 1'b0;
		instrWord = '0;
		void'($urandom(43398));
		loadVectors();
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkCount++;
		if (decValid !== 1'b0) begin
			errorCount++;
			$display("decValid is not low after reset");
		end
		checkCmd("reset", {CC_AL, NM_INVOP}, uCmd);
		checkReg("reset", "regN", GR_ZZR, regN);
		checkReg("reset", "regM", GR_ZZR, regM);
		checkReg("reset", "regO", GR_ZZR, regO);
		checkReg("reset", "regP", GR_ZZR, regP);
		foreach (vectors[i]) begin
			@(posedge clock);
			instrValid <= 1'b1;
			instrWord <= vectors[i].word;
			item = vectors[i];
			item.due = cycle + 1;
			pending.push_back(item);
			gap = $urandom % 4;
			repeat (gap) begin
				@(posedge clock);
				instrValid <= 1'b0;
				// junk while idle must never reach the outputs
				instrWord <= $urandom;
			end
		end
		@(posedge clock);
		instrValid <= 1'b0;
		waited = 0;
		while (pending.size() != 0 && waited < 20) begin
			@(posedge clock);
			waited++;
		end
		if (pending.size() != 0) begin
			errorCount++;
			$display("timed out waiting for decValid, %0d words left", pending.size());
		end
		$display("decoder checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* source/rvDecodeTop.sv */
/*
 one-stage RISC-V decoder, registered output one clock after instrValid
 accepts a word every cycle, the consumer must take every decValid
*/
`timescale 1ns/1ps

module rvDecodeTop (
	input logic clock,
	input logic reset,
	input logic instrValid,
	input rvDecodePkg::instrT instrWord,
	output logic decValid,
	output rvDecodePkg::regIdT regN,
	output rvDecodePkg::regIdT regM,
	output rvDecodePkg::regIdT regO,
	output rvDecodePkg::regIdT regP,
	output rvDecodePkg::immT imm,
	output rvDecodePkg::uCmdT uCmd,
	output rvDecodePkg::uIxtT uIxt
);
	import rvDecodePkg::*;

	immSetT imms;

	decodeCtrlIf ctrlBus ();
	regFieldIf regBus ();

	opcodeClassifier i_opcodeClassifier (
		.word(instrWord),
		.ctrl(ctrlBus.ctrl)
	);

	regFieldMapper i_regFieldMapper (
		.word(instrWord),
		.regs(regBus.map)
	);

	immediateGen i_immediateGen (
		.word(instrWord),
		.imms(imms)
	);

	operandRouter i_operandRouter (
		.clock(clock),
		.reset(reset),
		.valid(instrValid),
		.ctrlIf(ctrlBus.route),
		.regIf(regBus.route),
		.imms(imms),
		.word(instrWord),
		.decValid(decValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.regP(regP),
		.imm(imm),
		.uCmd(uCmd),
		.uIxt(uIxt)
	);

endmodule

/* source/operandRouter.sv */
/*
 operand routing per form and type, and the one output register
 outputs hold while valid is low, there is no back-pressure
 imm and uIxt are undefined until the first valid word
*/
`timescale 1ns/1ps

module operandRouter (
	input logic clock,
	input logic reset,
	input logic valid,
	decodeCtrlIf.route ctrlIf,
	regFieldIf.route regIf,
	input rvDecodePkg::immSetT imms,
	input rvDecodePkg::instrT word,
	output logic decValid,
	output rvDecodePkg::regIdT regN,
	output rvDecodePkg::regIdT regM,
	output rvDecodePkg::regIdT regO,
	output rvDecodePkg::regIdT regP,
	output rvDecodePkg::immT imm,
	output rvDecodePkg::uCmdT uCmd,
	output rvDecodePkg::uIxtT uIxt
);
	import rvDecodePkg::*;

	regIdT nRegN;
	regIdT nRegM;
	regIdT nRegO;
	regIdT nRegP;
	immT nImm;
	uCmdT nCmd;
	uIxtT nIxt;
	uIxtT memIxt;

	// access size spread over the extended command of loads and stores
	assign memIxt = {ctrlIf.ucty, ctrlIf.bty[1:0], 1'b0, ctrlIf.bty[2], 2'b00};

	always_comb begin
		nRegN = GR_ZZR;
		nRegM = GR_ZZR;
		nRegO = GR_ZZR;
		nRegP = GR_ZZR;
		nImm = '0;
		nCmd = {CC_AL, ctrlIf.nmid};
		nIxt = {ctrlIf.ucty, ctrlIf.ucmdIx};
		case (ctrlIf.fmid)
			FMID_LDREGDISPREG: begin
				nRegN = regIf.rnDfl;
				nRegP = regIf.rnDfl;
				nRegM = regIf.rmDfl;
				nRegO = GR_IMM;
				nImm = imms.imm12u;
				nIxt = memIxt;
			end
			FMID_REGSTREGDISP: begin
				nRegN = regIf.roDfl;
				nRegP = regIf.roDfl;
				nRegM = regIf.rmDfl;
				nRegO = GR_IMM;
				nImm = imms.dispS;
				nIxt = memIxt;
			end
			FMID_REGPC: begin
				nRegM = regIf.rmDfl;
				nRegO = regIf.roDfl;
				nImm = imms.dispB;
			end
			FMID_PCDISP8: begin
				nRegN = regIf.rnDfl;
				nRegP = regIf.rnDfl;
				nRegM = GR_PC;
				nRegO = GR_IMM;
				nImm = (ctrlIf.ity == ITY_SW) ? imms.dispJ : imms.upper;
				nIxt = {ctrlIf.ucty, ctrlIf.bty[1:0], 1'b0, ctrlIf.bty};
			end
			FMID_REGIMMREG: begin
				nRegN = regIf.rnDfl;
				nRegP = regIf.rnDfl;
				nRegM = regIf.rmDfl;
				nRegO = GR_IMM;
				nImm = imms.imm12s;
			end
			FMID_REGREG: begin
				nImm = imms.shamt;
				case (ctrlIf.ity)
					// move to a control register
					ITY_UL: begin
						nRegM = regIf.rmDfl;
						nRegO = regIf.crReg;
						nRegN = regIf.crReg;
						nRegP = regIf.crReg;
					end
					// move from a control register, also CPUID
					ITY_UQ: begin
						nRegM = regIf.crReg;
						nRegO = regIf.crReg;
						nRegN = regIf.rnDfl;
						nRegP = regIf.rnDfl;
					end
					default: begin
						nRegN = regIf.rnDfl;
						nRegP = regIf.rnDfl;
						nRegM = regIf.rmDfl;
						nRegO = regIf.roDfl;
						nImm = imms.imm12u;
					end
				endcase
			end
			FMID_IMM8REG: begin
				nRegN = regIf.rnDfl;
				nRegP = regIf.rnDfl;
				nRegM = regIf.rnDfl;
				nRegO = GR_IMM;
				nImm = imms.upper;
			end
			default: begin
				// FMID_Z and FMID_INV keep every register on ZZR
			end
		endcase
		if (ctrlIf.isInvalid)
			nCmd = {CC_AL, NM_INVOP};
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decValid <= 1'b0;
			uCmd <= {CC_AL, NM_INVOP};
			regN <= GR_ZZR;
			regM <= GR_ZZR;
			regO <= GR_ZZR;
			regP <= GR_ZZR;
		end else begin
			decValid <= valid;
			if (valid) begin
				uCmd <= nCmd;
				regN <= nRegN;
				regM <= nRegM;
				regO <= nRegO;
				regP <= nRegP;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (valid) begin
			imm <= nImm;
			uIxt <= nIxt;
		end
	end

	decValidKnown: assert property (@(posedge clock) disable iff (reset) !$isunknown(decValid))
		else $error("decValid unknown");

	// a non-32-bit encoding must come out as INVOP one cycle later
	badLowBits: assert property (@(posedge clock) disable iff (reset)
		valid && word[1:0] != 2'b11 |=> uCmd == {CC_AL, NM_INVOP})
		else $error("short encoding not rejected");

endmodule

/* source/immediateGen.sv */
/*
 all immediate formats of a word at once
 branch and jump displacements stay in halfword units
 shamt is six bits wide for the 64-bit shifter
*/
`timescale 1ns/1ps

`include "rvDecode_defines.svh"

module immediateGen (
	input rvDecodePkg::instrT word,
	output rvDecodePkg::immSetT imms
);
	logic sign;

	assign sign = word[`INSTR_W-1];

	always_comb begin
		imms.imm12s = {{(`IMM_W-12){sign}}, word[31:20]};
		imms.imm12u = {{(`IMM_W-12){1'b0}}, word[31:20]};
		imms.dispS = {{(`IMM_W-12){sign}}, word[31:25], word[11:7]};
		imms.dispB = {{(`IMM_W-12){sign}}, word[31], word[7], word[30:25], word[11:8]};
		imms.dispJ = {{(`IMM_W-19){sign}}, word[19:12], word[20], word[30:21]};
		// bit 32 stays clear so LUI values are not sign extended
		imms.upper = {1'b0, word[31:12], 12'h000};
		imms.shamt = {{(`IMM_W-6){1'b0}}, word[25:20]};
	end

endmodule

/* source/regFieldMapper.sv */
/*
 register field remap to the core's selector space
 fields with bit 4 set are plain GPRs, the rest go through the remap table
 crReg covers CSR windows 0x7C0, 0xBC0 and 0xFC0 only
*/
`timescale 1ns/1ps

module regFieldMapper (
	input rvDecodePkg::instrT word,
	regFieldIf.map regs
);
	import rvDecodePkg::*;

	function automatic regIdT mapField(input logic [4:0] field);
		regIdT code;
		code = grGpr(field);
		if (!field[4]) begin
			case (field[3:0])
				4'd0: code = GR_ZZR;
				4'd1: code = GR_LR;
				4'd2: code = GR_SP;
				4'd3: code = GR_GBR;
				4'd4: code = GR_TBR;
				4'd5: code = GR_DHR;
				4'd6: code = GR_DLR;
				4'd14: code = grGpr(5'd2);
				4'd15: code = grGpr(5'd3);
				// 7 to 13 keep their own number
				default: code = grGpr(field);
			endcase
		end
		return code;
	endfunction

	assign regs.rnDfl = mapField(word[11:7]);
	assign regs.rmDfl = mapField(word[19:15]);
	assign regs.roDfl = mapField(word[24:20]);

	always_comb begin
		casez (word[31:20])
			12'b0111_11??_????: regs.crReg = GR_CR_BASE + {1'b0, ~word[25], word[24:20]};
			12'b1011_11??_????: regs.crReg = {1'b0, word[25:20]};
			12'b1111_11??_????: regs.crReg = {1'b0, word[25:20]};
			default: regs.crReg = GR_ZZR;
		endcase
	end

endmodule

/* source/opcodeClassifier.sv */
/*
 purely combinational opcode classifier for RV32I plus M
 OP-IMM-32, OP-32 and every opcode not listed below come out as FMID_INV,
 as do words whose low two bits are not 2'b11
 funct7 is only looked at to pick the multiply/divide group
*/
`timescale 1ns/1ps

module opcodeClassifier (
	input rvDecodePkg::instrT word,
	decodeCtrlIf.ctrl ctrl
);
	import rvDecodePkg::*;

	localparam logic [4:0] OPC_LOAD = 5'b00000;
	localparam logic [4:0] OPC_STORE = 5'b01000;
	localparam logic [4:0] OPC_BRANCH = 5'b11000;
	localparam logic [4:0] OPC_JALR = 5'b11001;
	localparam logic [4:0] OPC_JAL = 5'b11011;
	localparam logic [4:0] OPC_OPIMM = 5'b00100;
	localparam logic [4:0] OPC_OP = 5'b01100;
	localparam logic [4:0] OPC_SYSTEM = 5'b11100;
	localparam logic [4:0] OPC_AUIPC = 5'b00101;
	localparam logic [4:0] OPC_LUI = 5'b01101;

	logic [2:0] funct3;
	logic rdZero;
	logic rs1Zero;
	logic isRegOp;
	logic csrCpuid;
	logic sysHit;
	ucmdIxT sysIx;

	assign funct3 = word[14:12];
	assign rdZero = (word[11:7] == 5'd0);
	assign rs1Zero = (word[19:15] == 5'd0);
	assign isRegOp = (word[6:2] == OPC_OP);
	assign csrCpuid = (word[31:26] == 6'b111111);

	// ECALL, EBREAK, return and SLEEP share funct3 0
	always_comb begin
		sysHit = 1'b1;
		case (word[23:20])
			4'h0: sysIx = UX_IXT_SYSE;
			4'h1: sysIx = UX_IXT_BREAK;
			4'h2: sysIx = UX_IXT_RTE;
			4'h5: sysIx = UX_IXT_SLEEP;
			default: begin
				sysHit = 1'b0;
				sysIx = UX_IXT_SYSE;
			end
		endcase
	end

	always_comb begin
		ctrl.nmid = NM_INVOP;
		ctrl.fmid = FMID_INV;
		ctrl.ity = ITY_SB;
		ctrl.bty = BTY_SB;
		ctrl.ucmdIx = UX_ALU_ADD;
		ctrl.ucty = IUC_SC;
		if (word[1:0] == 2'b11) begin
			case (word[6:2])
				OPC_LOAD, OPC_STORE: begin
					ctrl.nmid = (word[5]) ? NM_MOV_RM : NM_MOV_MR;
					ctrl.fmid = (word[5]) ? FMID_REGSTREGDISP : FMID_LDREGDISPREG;
					ctrl.bty = funct3;
					// unsigned quad goes to the wide unit
					if (funct3 == BTY_UQ)
						ctrl.ucty = IUC_WX;
				end
				OPC_BRANCH: begin
					ctrl.nmid = NM_JCMP;
					ctrl.fmid = FMID_REGPC;
					ctrl.ity = ITY_UB;
					case (funct3)
						3'd1: ctrl.ucmdIx = UX_JCMP_QNE;
						3'd4: ctrl.ucmdIx = UX_JCMP_QLT;
						3'd5: ctrl.ucmdIx = UX_JCMP_QGE;
						3'd6: ctrl.ucmdIx = UX_JCMP_QBL;
						3'd7: ctrl.ucmdIx = UX_JCMP_QHS;
						default: ctrl.ucmdIx = UX_JCMP_QEQ;
					endcase
				end
				OPC_JAL, OPC_JALR: begin
					ctrl.nmid = (rdZero) ? NM_JMP : NM_JSR;
					ctrl.fmid = (word[3]) ? FMID_PCDISP8 : FMID_REGIMMREG;
					ctrl.ity = ITY_SW;
					ctrl.bty = BTY_SW;
				end
				OPC_OPIMM, OPC_OP: begin
					ctrl.nmid = NM_ALU3;
					ctrl.fmid = (isRegOp) ? FMID_REGREG : FMID_REGIMMREG;
					ctrl.ity = (isRegOp) ? ITY_SB : ITY_SW;
					if (isRegOp && word[31:25] == 7'h01) begin
						ctrl.nmid = NM_QMULDIV;
						case (funct3)
							3'd0: ctrl.ucmdIx = UX_QMUL_MULS;
							3'd1: ctrl.ucmdIx = UX_QMUL_MULHS;
							3'd2: ctrl.ucmdIx = UX_QMUL_MULHSU;
							3'd3: ctrl.ucmdIx = UX_QMUL_MULHU;
							3'd4: ctrl.ucmdIx = UX_QMUL_DIVS;
							3'd5: ctrl.ucmdIx = UX_QMUL_DIVU;
							3'd6: ctrl.ucmdIx = UX_QMUL_MODS;
							default: ctrl.ucmdIx = UX_QMUL_MODU;
						endcase
					end else begin
						case (funct3)
							// bit 30 is immediate data in OP-IMM
							3'd0: ctrl.ucmdIx = (isRegOp && word[30]) ? UX_ALU_SUB : UX_ALU_ADD;
							3'd1: begin
								ctrl.nmid = NM_SHADQ3;
								ctrl.ucmdIx = UX_SHAD_SHLDQ3;
							end
							3'd2: ctrl.ucmdIx = UX_ALU_SLTSQ;
							3'd3: ctrl.ucmdIx = UX_ALU_SLTUQ;
							3'd4: ctrl.ucmdIx = UX_ALU_XOR;
							3'd5: begin
								ctrl.nmid = NM_SHADQ3;
								ctrl.ucmdIx = (word[30]) ? UX_SHAD_SHARQ3 : UX_SHAD_SHLRQ3;
							end
							3'd6: ctrl.ucmdIx = UX_ALU_OR;
							default: ctrl.ucmdIx = UX_ALU_AND;
						endcase
					end
				end
				OPC_LUI: begin
					ctrl.nmid = NM_MOV_IR;
					ctrl.fmid = FMID_IMM8REG;
					ctrl.ity = ITY_UB;
					ctrl.ucmdIx = UX_LDI_LDIX;
				end
				OPC_AUIPC: begin
					ctrl.nmid = NM_LEA_MR;
					ctrl.fmid = FMID_PCDISP8;
				end
				OPC_SYSTEM: begin
					// unmatched SYSTEM words stay REGREG with INVOP
					ctrl.fmid = FMID_REGREG;
					if (funct3 == 3'd0 && sysHit) begin
						ctrl.nmid = NM_OP_IXT;
						ctrl.fmid = FMID_Z;
						ctrl.ucmdIx = sysIx;
					end
					if (funct3 == 3'd1 && rdZero) begin
						ctrl.nmid = NM_MOV_RC;
						ctrl.ity = ITY_UL;
					end
					if ((funct3 == 3'd2 || funct3 == 3'd3) && rs1Zero) begin
						ctrl.nmid = NM_MOV_CR;
						ctrl.ity = ITY_UQ;
					end
					// CPUID wins over the plain CSR read
					if (funct3 == 3'd2 && csrCpuid) begin
						ctrl.nmid = NM_OP_IXT;
						ctrl.ucmdIx = UX_IXT_CPUID;
						ctrl.ity = ITY_UQ;
					end
				end
				default: begin
					ctrl.fmid = FMID_INV;
				end
			endcase
		end
	end

	assign ctrl.isInvalid = (ctrl.fmid == FMID_INV);

	invalidIsInvop: assert final (!ctrl.isInvalid || ctrl.nmid == NM_INVOP)
		else $error("invalid form with operation %h", ctrl.nmid);

endmodule

/* source/regFieldIf.sv */
/*
 mapped register candidates, rd, rs1 and rs2 after the remap
 crReg is ZZR for CSR numbers outside the mapped windows
*/
`timescale 1ns/1ps

interface regFieldIf;
	import rvDecodePkg::*;

	regIdT rnDfl;
	regIdT rmDfl;
	regIdT roDfl;
	regIdT crReg;

	modport map (output rnDfl, rmDfl, roDfl, crReg);
	modport route (input rnDfl, rmDfl, roDfl, crReg);

endinterface

/* source/decodeCtrlIf.sv */
/*
 instruction class from the classifier to the router
 all fields are combinational within one cycle
 isInvalid is only a shorthand for fmid being FMID_INV
*/
`timescale 1ns/1ps

interface decodeCtrlIf;
	import rvDecodePkg::*;

	nmidT nmid;
	fmidT fmid;
	ityT ity;
	btyT bty;
	ucmdIxT ucmdIx;
	uctyT ucty;
	logic isInvalid;

	modport ctrl (output nmid, fmid, ity, bty, ucmdIx, ucty, isInvalid);
	modport route (input nmid, fmid, ity, bty, ucmdIx, ucty, isInvalid);

endinterface

/* source/rvDecodePkg.sv */
/*
 types and codes of the decoder's micro-op form
 register codes use the core's 7-bit selector space, GPRs at 0x00-0x1F
 and control registers from 0x40, so DLR, DHR and SP alias R0, R1, R15
 sub-operation codes are only unique within one major operation
*/
`include "rvDecode_defines.svh"

package rvDecodePkg;

	typedef logic [`INSTR_W-1:0] instrT;
	typedef logic [`REGID_W-1:0] regIdT;
	typedef logic [`IMM_W-1:0] immT;
	typedef logic [`UCMD_W-1:0] uCmdT;
	typedef logic [`UIXT_W-1:0] uIxtT;
	typedef logic [5:0] nmidT;
	typedef logic [5:0] ucmdIxT;
	typedef logic [2:0] uctyT;
	typedef logic [2:0] ccT;
	typedef logic [2:0] btyT;

	// operand form, picks the routing in the router
	typedef enum logic [4:0] {
		FMID_Z, FMID_REGREG, FMID_REGIMMREG,
		FMID_LDREGDISPREG, FMID_REGSTREGDISP, FMID_IMM8REG,
		FMID_REGPC, FMID_PCDISP8, FMID_INV
	} fmidT;

	// operand type, a variant within one form
	typedef enum logic [3:0] {
		ITY_SB = 4'h0, ITY_SW = 4'h1, ITY_UB = 4'h4, ITY_UL = 4'h6, ITY_UQ = 4'h7
	} ityT;

	// every immediate format of the word, already extended to IMM_W
	typedef struct packed {
		immT imm12s;
		immT imm12u;
		immT dispS;
		immT dispB;
		immT dispJ;
		immT upper;
		immT shamt;
	} immSetT;

	localparam regIdT GR_DLR = 7'h00;
	localparam regIdT GR_DHR = 7'h01;
	localparam regIdT GR_SP = 7'h0F;
	localparam regIdT GR_CR_BASE = 7'h40;
	localparam regIdT GR_PC = 7'h40;
	localparam regIdT GR_LR = 7'h41;
	localparam regIdT GR_GBR = 7'h46;
	localparam regIdT GR_TBR = 7'h47;
	localparam regIdT GR_IMM = 7'h5E;
	localparam regIdT GR_ZZR = 7'h5F;

	// code of GPR n
	function automatic regIdT grGpr(input logic [4:0] n);
		return {2'b00, n};
	endfunction

	localparam nmidT NM_MOV_RM = 6'h01;
	localparam nmidT NM_MOV_MR = 6'h02;
	localparam nmidT NM_MOV_IR = 6'h04;
	localparam nmidT NM_LEA_MR = 6'h05;
	localparam nmidT NM_JMP = 6'h08;
	localparam nmidT NM_JSR = 6'h09;
	localparam nmidT NM_JCMP = 6'h0A;
	localparam nmidT NM_ALU3 = 6'h10;
	localparam nmidT NM_SHADQ3 = 6'h11;
	localparam nmidT NM_QMULDIV = 6'h12;
	localparam nmidT NM_MOV_RC = 6'h18;
	localparam nmidT NM_MOV_CR = 6'h19;
	localparam nmidT NM_OP_IXT = 6'h1C;
	localparam nmidT NM_INVOP = 6'h3F;

	localparam ucmdIxT UX_JCMP_QEQ = 6'h10;
	localparam ucmdIxT UX_JCMP_QNE = 6'h11;
	localparam ucmdIxT UX_JCMP_QLT = 6'h14;
	localparam ucmdIxT UX_JCMP_QGE = 6'h15;
	localparam ucmdIxT UX_JCMP_QBL = 6'h16;
	localparam ucmdIxT UX_JCMP_QHS = 6'h17;
	localparam ucmdIxT UX_ALU_ADD = 6'h00;
	localparam ucmdIxT UX_ALU_SUB = 6'h01;
	localparam ucmdIxT UX_ALU_AND = 6'h05;
	localparam ucmdIxT UX_ALU_OR = 6'h06;
	localparam ucmdIxT UX_ALU_XOR = 6'h07;
	localparam ucmdIxT UX_ALU_SLTSQ = 6'h0C;
	localparam ucmdIxT UX_ALU_SLTUQ = 6'h0D;
	localparam ucmdIxT UX_SHAD_SHLDQ3 = 6'h00;
	localparam ucmdIxT UX_SHAD_SHLRQ3 = 6'h01;
	localparam ucmdIxT UX_SHAD_SHARQ3 = 6'h02;
	localparam ucmdIxT UX_QMUL_MULS = 6'h00;
	localparam ucmdIxT UX_QMUL_MULHS = 6'h01;
	localparam ucmdIxT UX_QMUL_MULHSU = 6'h02;
	localparam ucmdIxT UX_QMUL_MULHU = 6'h03;
	localparam ucmdIxT UX_QMUL_DIVS = 6'h04;
	localparam ucmdIxT UX_QMUL_DIVU = 6'h05;
	localparam ucmdIxT UX_QMUL_MODS = 6'h06;
	localparam ucmdIxT UX_QMUL_MODU = 6'h07;
	localparam ucmdIxT UX_IXT_SYSE = 6'h00;
	localparam ucmdIxT UX_IXT_BREAK = 6'h01;
	localparam ucmdIxT UX_IXT_RTE = 6'h02;
	localparam ucmdIxT UX_IXT_SLEEP = 6'h03;
	localparam ucmdIxT UX_IXT_CPUID = 6'h08;
	localparam ucmdIxT UX_LDI_LDIX = 6'h20;

	// scalar and wide unit classes
	localparam uctyT IUC_SC = 3'h0;
	localparam uctyT IUC_WX = 3'h1;

	localparam ccT CC_AL = 3'h0;

	localparam btyT BTY_SB = 3'h0;
	localparam btyT BTY_SW = 3'h1;
	localparam btyT BTY_UQ = 3'h7;

endpackage

/* source/rvDecode_defines.svh */
/*
 width macros shared by the package and the RTL
 changing a width here changes every decoder stage, and the
 register and command codes in the package must still fit
*/
`ifndef RVDECODE_DEFINES_SVH
`define RVDECODE_DEFINES_SVH

// raw RV32 instruction word
`define INSTR_W 32

// internal register selector
`define REGID_W 7

// immediate as seen by the execute stage
`define IMM_W 33

// command word and extended command
`define UCMD_W 9
`define UIXT_W 9

`endif
